/* Makefile */
VERILATOR ?= verilator
TOP ?= dinoGameTb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= No errors
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
HEADERS := $(wildcard include/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILE_LIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/dinoGameTb.sv */
`timescale 1ns/1ps

module dinoGameTb;
    import dinoGeomPkg::*;
    import dinoGamePkg::*;

    `include "jumpProfile.svh"

    // Short periods so a long run fits in simulation
    localparam int TickCycles = 2;
    localparam int JumpStepCycles = 3;
    localparam int ScoreCap = 999999;

    logic clk;
    logic resetn;
    logic jump;
    gameStateT gameState;
    sceneT scene;
    scoreT score;
    logic collision;

    // Reference model state
    int mCount;
    int mPeriod;
    bit mTick;
    int mScore;
    int mSpeed;
    bit mArcOn;
    int mArcClk;
    int mDinoY;
    int mAx;
    int mBx;
    bit mColl;

    int mismatches;
    int timeouts;
    // Jump chance out of 64 per cycle
    int jumpOdds;

    dinoGameCore #(
        .TickCycles    (TickCycles),
        .JumpStepCycles(JumpStepCycles)
    ) UUT (
        .clk      (clk),
        .resetn   (resetn),
        .jump     (jump),
        .gameState(gameState),
        .scene    (scene),
        .score    (score),
        .collision(collision)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Decimal count into six BCD digits, ones in the low nibble
    function automatic scoreT toBcd(int value);
        logic [23:0] digits;
        int rest;
        rest = value;
        for (int i = 0; i < 6; i++) begin
            digits[i*4 +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return scoreT'(digits);
    endfunction

    // Level from the score thresholds
    function automatic int levelFor(int value);
        if (value >= 10000) return 3;
        if (value >= 1000) return 2;
        return 1;
    endfunction

    // Near obstacle overlap and height rule
    function automatic bit hits(int ax, int bx, int dinoY);
        int nearX;
        int nearH;
        int rightX;
        bit inX;
        if (ax < bx && ax >= int'(dinoLeft) - int'(obsW)) begin
            nearX = ax;
            nearH = int'(minObsH);
        end else begin
            nearX = bx;
            nearH = int'(maxObsH);
        end
        rightX = (nearX + int'(obsW)) % 256;
        inX = (nearX >= int'(dinoLeft) && nearX <= int'(dinoRight)) ||
              (rightX >= int'(dinoLeft) && rightX <= int'(dinoRight));
        return inX && (int'(groundTop) - nearH < dinoY + int'(dinoH));
    endfunction

    task automatic clearModel();
        mCount = 0;
        mPeriod = TickCycles * (speedSpan - 1);
        mTick = 1'b0;
        mScore = 0;
        mSpeed = 1;
        mArcOn = 1'b0;
        mArcClk = 0;
        mDinoY = int'(dinoRestY);
        mAx = int'(obsStartX[0]);
        mBx = int'(obsStartX[1]);
        mColl = 1'b0;
    endtask

    // Cycle model, sees the inputs as the DUT samples them
    always @(posedge clk) begin : refModel
        bit tk;
        int sp;
        int elevNow;
        bit run;
        tk = mTick;
        sp = mSpeed;
        elevNow = mArcOn ? int'(jumpTable[mArcClk / JumpStepCycles]) : 0;
        run = gameState == gameRunning;
        if (!resetn || gameState == gameMenu) begin
            clearModel();
        end else begin
            if (run && hits(mAx, mBx, mDinoY)) begin
                mColl = 1'b1;
            end
            mDinoY = int'(dinoRestY) - elevNow;
            mSpeed = levelFor(mScore);
            if (run && tk) begin
                mAx = (mAx + 255) % 256;
                mBx = (mBx + 255) % 256;
                if (mScore < ScoreCap) begin
                    mScore++;
                end
            end
            // Arc runs jumpSteps entries of JumpStepCycles clocks each
            if (run) begin
                if (mArcOn) begin
                    mArcClk++;
                    if (mArcClk == jumpSteps * JumpStepCycles) begin
                        mArcOn = 1'b0;
                        mArcClk = 0;
                    end
                end else if (jump) begin
                    mArcOn = 1'b1;
                    mArcClk = 0;
                end
            end
            // Step period counted in running clocks, speed taken at wrap
            if (run) begin
                mCount++;
                if (mCount == mPeriod) begin
                    mTick = 1'b1;
                    mCount = 0;
                    mPeriod = TickCycles * (speedSpan - sp);
                end else begin
                    mTick = 1'b0;
                end
            end else begin
                mTick = 1'b0;
            end
        end
    end

    task automatic compareField(string name, int got, int exp);
        assert (got == exp) else begin
            $display("MISMATCH %s: dut=%h model=%h", name, got, exp);
            mismatches++;
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (resetn) begin
            compareField("scene.dinoY", int'(scene.dinoY), mDinoY);
            compareField("scene.obsA.x", int'(scene.obsA.x), mAx);
            compareField("scene.obsA.height", int'(scene.obsA.height), int'(minObsH));
            compareField("scene.obsB.x", int'(scene.obsB.x), mBx);
            compareField("scene.obsB.height", int'(scene.obsB.height), int'(maxObsH));
            compareField("score", int'(score), int'(toBcd(mScore)));
            compareField("collision", int'(collision), int'(mColl));
        end
    end

    function automatic gameStateT pickState();
        case ($urandom % 4)
            0: return gameMenu;
            3: return gameOver;
            default: return gameRunning;
        endcase
    endfunction

    task automatic stepCycles(int n, gameStateT st);
        repeat (n) begin
            @(posedge clk);
            gameState <= st;
            jump <= (int'($urandom % 64) < jumpOdds);
        end
    endtask

    task automatic waitForScore(int target, int limit);
        int n;
        n = 0;
        while (mScore < target && n < limit) begin
            stepCycles(1, gameRunning);
            @(negedge clk);
            n++;
        end
        if (mScore < target) begin
            $display("Timeout: score stuck below %0d after %0d cycles", target, limit);
            timeouts++;
        end
    endtask

    // Clocks from one score step of the DUT to the next
    task automatic measureStepGap(int expGap, int limit);
        int n;
        int gap;
        scoreT last;
        n = 0;
        last = score;
        while (score == last && n < limit) begin
            stepCycles(1, gameRunning);
            @(negedge clk);
            n++;
        end
        gap = 0;
        last = score;
        while (score == last && gap < limit) begin
            stepCycles(1, gameRunning);
            @(negedge clk);
            gap++;
        end
        if (score == last) begin
            $display("Timeout: no score step within %0d cycles", limit);
            timeouts++;
        end else begin
            compareField("step gap", gap, expGap);
        end
    endtask

    task automatic waitForGround(int limit);
        int n;
        n = 0;
        while (mArcOn && n < limit) begin
            stepCycles(1, gameRunning);
            @(negedge clk);
            n++;
        end
        if (mArcOn) begin
            $display("Timeout: jump arc still active after %0d cycles", limit);
            timeouts++;
        end
    endtask

    initial begin
        int savedScore;
        int savedAx;
        int savedY;
        void'($urandom(2));
        mismatches = 0;
        timeouts = 0;
        jumpOdds = 3;
        resetn = 1'b0;
        jump = 1'b0;
        gameState = gameMenu;
        clearModel();
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        // Random mix of menu, running and game over
        for (int run = 0; run < 40; run++) begin
            stepCycles(20 + int'($urandom % 200), pickState());
        end

        // Forced jump, then heavy presses while airborne
        stepCycles(4, gameMenu);
        jumpOdds = 64;
        stepCycles(1, gameRunning);
        jumpOdds = 32;
        stepCycles(20, gameRunning);
        jumpOdds = 0;
        waitForGround(400);

        // Pause mid arc and check that play is frozen
        jumpOdds = 64;
        stepCycles(30, gameRunning);
        stepCycles(2, gameOver);
        @(negedge clk);
        savedScore = mScore;
        savedAx = mAx;
        savedY = mDinoY;
        stepCycles(100, gameOver);
        @(negedge clk);
        compareField("paused score", int'(score), int'(toBcd(savedScore)));
        compareField("paused scene.obsA.x", int'(scene.obsA.x), savedAx);
        compareField("paused scene.dinoY", int'(scene.dinoY), savedY);

        // Long run through both speed thresholds
        jumpOdds = 2;
        stepCycles(3, gameMenu);
        waitForScore(1050, 10000);
        measureStepGap(TickCycles * (speedSpan - 2), 100);
        waitForScore(10050, 50000);
        measureStepGap(TickCycles * (speedSpan - 3), 100);
        stepCycles(5, gameMenu);
        @(negedge clk);

        $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* bench/dinoGame_properties.sv */
`timescale 1ns/1ps

module dinoGameProperties (
    input logic                   clk,
    input logic                   resetn,
    input dinoGamePkg::gameStateT gameState,
    input logic                   tick,
    input dinoGamePkg::scoreT     score,
    input dinoGamePkg::sceneT     scene,
    input logic                   collision
);
    import dinoGeomPkg::*;
    import dinoGamePkg::*;

    // All six digits in decimal range
    function automatic logic digitsOk(scoreT s);
        return s.ones <= 4'd9 && s.tens <= 4'd9 && s.hundreds <= 4'd9 &&
               s.thousands <= 4'd9 && s.tenThousands <= 4'd9 &&
               s.hundredThousands <= 4'd9;
    endfunction

    // Scroll step is a lone pulse
    tickSingle: assert property (@(posedge clk) disable iff (!resetn)
        tick |=> !tick)
        else $error("tick high for two cycles in a row");

    // Latched hit survives the run
    collisionSticky: assert property (@(posedge clk) disable iff (!resetn)
        collision && gameState == gameRunning |=> collision)
        else $error("collision dropped while running");

    scoreDigits: assert property (@(posedge clk) disable iff (!resetn)
        digitsOk(score))
        else $error("score digit above nine");

    // Dino never sinks below the ground
    dinoAboveGround: assert property (@(posedge clk) disable iff (!resetn)
        scene.dinoY <= dinoRestY)
        else $error("dinoY below rest position");

endmodule

bind dinoGameCore dinoGameProperties uProps (
    .clk      (clk),
    .resetn   (resetn),
    .gameState(gameState),
    .tick     (tick),
    .score    (score),
    .scene    (scene),
    .collision(collision)
);

/* include/jumpProfile.svh */
// Elevation per jump step
// Coarse parabola, 32 steps up, 32 at the top, 32 back down
// Indexed by step number, entry 0 first
// Pulled into module scope, each includer gets its own copy
localparam dinoGamePkg::elevT jumpTable [dinoGamePkg::jumpSteps] = '{
    // Rise, fast at first then slowing
    6'd0,  6'd3,  6'd6,  6'd9,  6'd11, 6'd14, 6'd16, 6'd19,
    6'd21, 6'd23, 6'd25, 6'd27, 6'd29, 6'd30, 6'd32, 6'd33,
    6'd35, 6'd36, 6'd37, 6'd39, 6'd40, 6'd41, 6'd42, 6'd42,
    6'd43, 6'd44, 6'd44, 6'd45, 6'd45, 6'd46, 6'd46, 6'd46,
    // Hang time at the apex
    6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47,
    6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47,
    6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47,
    6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47, 6'd47,
    // Fall, mirror of the rise
    6'd46, 6'd46, 6'd46, 6'd45, 6'd45, 6'd44, 6'd44, 6'd43,
    6'd42, 6'd42, 6'd41, 6'd40, 6'd39, 6'd37, 6'd36, 6'd35,
    6'd33, 6'd32, 6'd30, 6'd29, 6'd27, 6'd25, 6'd23, 6'd21,
    6'd19, 6'd16, 6'd14, 6'd11, 6'd9,  6'd6,  6'd3,  6'd0
};

/* logic/dinoGameCore.sv */
`timescale 1ns/1ps

module dinoGameCore #(
    parameter int TickCycles = 86655,
    parameter int JumpStepCycles = 22000
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   jump,
    input  dinoGamePkg::gameStateT gameState,
    output dinoGamePkg::sceneT     scene,
    output dinoGamePkg::scoreT     score,
    output logic                   collision
);
    import dinoGamePkg::*;

    // Scroll step pulse
    logic tick;
    // Level fed back from the score
    speedT speed;
    // Dino height above ground
    elevT elev;

    scrollTicker #(
        .TickCycles(TickCycles)
    ) uTicker (
        .clk      (clk),
        .resetn   (resetn),
        .gameState(gameState),
        .speed    (speed),
        .tick     (tick)
    );

    jumpArc #(
        .JumpStepCycles(JumpStepCycles)
    ) uJump (
        .clk      (clk),
        .resetn   (resetn),
        .jump     (jump),
        .gameState(gameState),
        .elev     (elev)
    );

    scoreKeeper uScore (
        .clk      (clk),
        .resetn   (resetn),
        .gameState(gameState),
        .tick     (tick),
        .score    (score),
        .speed    (speed)
    );

    obstacleField uField (
        .clk      (clk),
        .resetn   (resetn),
        .gameState(gameState),
        .tick     (tick),
        .elev     (elev),
        .scene    (scene),
        .collision(collision)
    );

endmodule

/* logic/dinoGamePkg.sv */
package dinoGamePkg;

    // Game mode, driven from outside the core
    typedef enum logic [1:0] {
        gameMenu,
        gameRunning,
        gameOver
    } gameStateT;

    // One decimal display digit
    typedef logic [3:0] bcdDigitT;

    // Six digit score
    // Most significant digit first so the packed value reads as hex
    typedef struct packed {
        bcdDigitT hundredThousands;
        bcdDigitT tenThousands;
        bcdDigitT thousands;
        bcdDigitT hundreds;
        bcdDigitT tens;
        bcdDigitT ones;
    } scoreT;

    // Score saturates here
    localparam scoreT scoreMax = 24'h999999;

    // Speed level, higher is faster
    typedef logic [1:0] speedT;

    localparam speedT speedSlow = 2'd1;
    localparam speedT speedMid = 2'd2;
    localparam speedT speedFast = 2'd3;

    // Single obstacle, x is its left edge
    typedef struct packed {
        dinoGeomPkg::pixelT x;
        dinoGeomPkg::pixelT height;
    } obstacleT;

    // Everything the renderer needs
    typedef struct packed {
        dinoGeomPkg::pixelT dinoY;
        obstacleT obsA;
        obstacleT obsB;
    } sceneT;

    // Jump height above the ground
    typedef logic [5:0] elevT;

    // Entries in the jump table
    localparam int jumpSteps = 96;

    // Score digits that select the faster levels
    localparam int speedUpThousands = 1;
    localparam int speedTopTenThousands = 1;

    // Scroll period multiplier is speedSpan minus the level
    localparam int speedSpan = 4;

endpackage

/* logic/dinoGeomPkg.sv */
package dinoGeomPkg;

    // One byte per screen coordinate
    // Origin is top left, y grows downward
    typedef logic [7:0] pixelT;

    // Ground line
    // Everything stands on this y
    localparam pixelT groundTop = 8'd200;

    // Dino bounding box
    localparam pixelT dinoH = 8'd20;
    localparam pixelT dinoLeft = 8'd40;
    localparam pixelT dinoRight = 8'd60;

    // Top edge of the dino when standing
    localparam pixelT dinoRestY = groundTop - dinoH;

    // Obstacle footprint
    localparam pixelT obsW = 8'd10;

    // Short and tall obstacle heights
    localparam pixelT minObsH = 8'd15;
    localparam pixelT maxObsH = 8'd30;

    // Start x per obstacle
    // Entry 0 is obstacle A at the far right, entry 1 is obstacle B
    localparam pixelT [1:0] obsStartX = {8'd32, 8'd254};

endpackage

/* logic/jumpArc.sv */
`timescale 1ns/1ps

module jumpArc #(
    parameter int JumpStepCycles = 22000
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   jump,
    input  dinoGamePkg::gameStateT gameState,
    output dinoGamePkg::elevT      elev
);
    import dinoGamePkg::*;

    `include "jumpProfile.svh"

    localparam int PreW = $clog2(JumpStepCycles + 1);
    localparam int IdxW = $clog2(jumpSteps);

    // Idle means the dino is on the ground
    typedef enum logic {
        arcIdle,
        arcActive
    } arcStateT;

    arcStateT state;
    // Clocks spent on the current table entry
    logic [PreW-1:0] preCount;
    logic [IdxW-1:0] stepIdx;
    logic stepDone;
    logic lastStep;

    assign stepDone = preCount == PreW'(JumpStepCycles - 1);
    assign lastStep = stepIdx == IdxW'(jumpSteps - 1);

    always_ff @(posedge clk) begin
        if (!resetn || gameState == gameMenu) begin
            state <= arcIdle;
            preCount <= '0;
            stepIdx <= '0;
        end else if (gameState == gameRunning) begin
            case (state)
                arcIdle: begin
                    // Only a grounded dino can take off
                    if (jump) begin
                        state <= arcActive;
                        preCount <= '0;
                        stepIdx <= '0;
                    end
                end
                arcActive: begin
                    // Jump presses mid air fall through here
                    if (stepDone) begin
                        preCount <= '0;
                        if (lastStep) begin
                            state <= arcIdle;
                        end else begin
                            stepIdx <= stepIdx + IdxW'(1);
                        end
                    end else begin
                        preCount <= preCount + PreW'(1);
                    end
                end
                default: state <= arcIdle;
            endcase
        end
    end

    // Table lookup, zero on the ground
    assign elev = (state == arcActive) ? jumpTable[stepIdx] : '0;

endmodule

/* logic/obstacleField.sv */
`timescale 1ns/1ps

module obstacleField (
    input  logic                   clk,
    input  logic                   resetn,
    input  dinoGamePkg::gameStateT gameState,
    input  logic                   tick,
    input  dinoGamePkg::elevT      elev,
    output dinoGamePkg::sceneT     scene,
    output logic                   collision
);
    import dinoGeomPkg::*;
    import dinoGamePkg::*;

    // Obstacle closest to the dino and its edges
    obstacleT nearObs;
    pixelT nearRight;
    pixelT nearTop;
    pixelT dinoBottom;
    logic pickA;
    logic leftIn;
    logic rightIn;
    logic overlapX;
    logic overlapY;
    logic running;

    assign running = gameState == gameRunning;

    // A is near when it leads B and has not fully passed the dino
    assign pickA = (scene.obsA.x < scene.obsB.x) &&
                   (scene.obsA.x >= dinoLeft - obsW);
    assign nearObs = pickA ? scene.obsA : scene.obsB;

    // Right edge wraps with the screen
    assign nearRight = nearObs.x + obsW;
    assign nearTop = groundTop - nearObs.height;
    assign dinoBottom = scene.dinoY + dinoH;

    // Either vertical edge inside the dino's column
    assign leftIn = (nearObs.x >= dinoLeft) && (nearObs.x <= dinoRight);
    assign rightIn = (nearRight >= dinoLeft) && (nearRight <= dinoRight);
    assign overlapX = leftIn || rightIn;

    // Obstacle top reaches above the dino's feet
    assign overlapY = nearTop < dinoBottom;

    always_ff @(posedge clk) begin
        if (!resetn || gameState == gameMenu) begin
            scene.dinoY <= dinoRestY;
            scene.obsA.x <= obsStartX[0];
            scene.obsA.height <= minObsH;
            scene.obsB.x <= obsStartX[1];
            scene.obsB.height <= maxObsH;
            collision <= 1'b0;
        end else begin
            // Dino height tracks the arc one cycle late
            scene.dinoY <= dinoRestY - pixelT'(elev);

            // One pixel left per scroll step, wraps past the left edge
            if (running && tick) begin
                scene.obsA.x <= scene.obsA.x - pixelT'(1);
                scene.obsB.x <= scene.obsB.x - pixelT'(1);
            end

            // Sticky until the menu
            if (running && overlapX && overlapY) begin
                collision <= 1'b1;
            end
        end
    end

endmodule

/* logic/scoreKeeper.sv */
`timescale 1ns/1ps

module scoreKeeper (
    input  logic                   clk,
    input  logic                   resetn,
    input  dinoGamePkg::gameStateT gameState,
    input  logic                   tick,
    output dinoGamePkg::scoreT     score,
    output dinoGamePkg::speedT     speed
);
    import dinoGamePkg::*;

    // Digit view of the score, index 0 is the ones digit
    bcdDigitT [5:0] nextDigits;
    logic carry;
    logic atMax;

    assign atMax = score == scoreMax;

    // Ripple incrementer, a 9 rolls to 0 and passes the carry up
    always_comb begin
        nextDigits = score;
        carry = 1'b1;
        for (int i = 0; i < 6; i++) begin
            if (carry) begin
                if (nextDigits[i] == bcdDigitT'(9)) begin
                    nextDigits[i] = '0;
                end else begin
                    nextDigits[i] = nextDigits[i] + bcdDigitT'(1);
                    carry = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || gameState == gameMenu) begin
            score <= '0;
            speed <= speedSlow;
        end else begin
            // A tick that lands after leaving the run is dropped
            if (tick && gameState == gameRunning && !atMax) begin
                score <= nextDigits;
            end
            // Level follows the registered score, one cycle behind
            if (score.tenThousands >= bcdDigitT'(speedTopTenThousands) ||
                score.hundredThousands != '0) begin
                speed <= speedFast;
            end else if (score.thousands >= bcdDigitT'(speedUpThousands)) begin
                speed <= speedMid;
            end else begin
                speed <= speedSlow;
            end
        end
    end

endmodule

/* logic/scrollTicker.sv */
`timescale 1ns/1ps

module scrollTicker #(
    parameter int TickCycles = 86655
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  dinoGamePkg::gameStateT gameState,
    input  dinoGamePkg::speedT     speed,
    output logic                   tick
);
    import dinoGamePkg::*;

    // Longest period is at the slowest level
    localparam int CntW = $clog2(TickCycles * (speedSpan - int'(speedSlow)) + 1);

    typedef logic [CntW-1:0] countT;

    countT count;
    // Terminal count of the period in progress
    countT lastCount;

    always_ff @(posedge clk) begin
        if (!resetn || gameState == gameMenu) begin
            count <= '0;
            lastCount <= countT'(TickCycles * (speedSpan - int'(speedSlow)) - 1);
            tick <= 1'b0;
        end else if (gameState == gameRunning) begin
            if (count == lastCount) begin
                count <= '0;
                // New speed only takes effect from the wrap on
                lastCount <= countT'(TickCycles * (speedSpan - int'(speed)) - 1);
                tick <= 1'b1;
            end else begin
                count <= count + countT'(1);
                tick <= 1'b0;
            end
        end else begin
            // Paused, count holds
            tick <= 1'b0;
        end
    end

endmodule

/* verilog.f */
+incdir+include
logic/dinoGeomPkg.sv
logic/dinoGamePkg.sv
logic/scrollTicker.sv
logic/jumpArc.sv
logic/scoreKeeper.sv
logic/obstacleField.sv
logic/dinoGameCore.sv
bench/dinoGame_properties.sv
bench/dinoGameTb.sv
